// File: src/fp_unpack_pkg.sv
// Shared types and constants for the FPU operand unpack front end
// Used by the RTL and by the testbench that drives it
package fp_unpack_pkg;

    typedef enum logic {
        FMT_SINGLE = 1'b0,
        FMT_DOUBLE = 1'b1
    } fmt_e;

    // Internal operand format, bias 2047
    localparam int unsigned EXP_W  = 12;
    localparam int unsigned FRAC_W = 52;
    localparam int unsigned INT_W  = 1 + EXP_W + FRAC_W;

    localparam logic [EXP_W-1:0] SP_REBIAS = 12'd1920;  // 2047 - 127
    localparam logic [EXP_W-1:0] DP_REBIAS = 12'd1024;  // 2047 - 1023

    // One-hot class, fclass bit order
    localparam int unsigned CLASS_W      = 10;
    localparam int unsigned CLS_NEG_INF  = 0;
    localparam int unsigned CLS_NEG_NORM = 1;
    localparam int unsigned CLS_NEG_SUB  = 2;
    localparam int unsigned CLS_NEG_ZERO = 3;
    localparam int unsigned CLS_POS_ZERO = 4;
    localparam int unsigned CLS_POS_SUB  = 5;
    localparam int unsigned CLS_POS_NORM = 6;
    localparam int unsigned CLS_POS_INF  = 7;
    localparam int unsigned CLS_SNAN     = 8;
    localparam int unsigned CLS_QNAN     = 9;

    typedef struct packed {
        logic [31:0] pad;   // Ignored in single format
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] mant;
    } fp_sp_view_t;

    typedef struct packed {
        logic        sign;
        logic [10:0] exp;
        logic [51:0] mant;
    } fp_dp_view_t;

    typedef union packed {
        fp_sp_view_t sp;
        fp_dp_view_t dp;
    } fp_word_u;

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp_int_t;

    typedef struct packed {
        fp_word_u data;
        fmt_e     fmt;
    } fp_ext_in_t;

    typedef struct packed {
        fp_int_t            result;
        logic [CLASS_W-1:0] cls;
    } fp_ext_out_t;

    typedef struct packed {
        fmt_e               fmt;
        logic [CLASS_W-1:0] class_mask;
    } fp_cfg_t;

endpackage

// File: src/fp_lzc64.sv
// Combinational 64-bit leading zero counter
// valid is low for an all-zero input, lzc then reads 63
`timescale 1ns/1ps

module fp_lzc64 (
    input  logic [63:0] data_in,
    output logic [5:0]  lzc,
    output logic        valid
);

    logic [5:0] cnt      [7][64];  // Zeros above the first set bit of a node
    logic       node_set [7][64];  // Node holds at least one set bit

    always_comb begin
        for (int l = 0; l < 7; l++) begin
            for (int n = 0; n < 64; n++) begin
                cnt[l][n]      = '0;
                node_set[l][n] = 1'b0;
            end
        end

        for (int n = 0; n < 64; n++) begin
            node_set[0][n] = data_in[63-n];  // Leaf 0 is the MSB
        end

        // Merge neighbours, the left node covers the higher bits
        for (int l = 0; l < 6; l++) begin
            for (int n = 0; n < (32 >> l); n++) begin
                node_set[l+1][n] = node_set[l][2*n] | node_set[l][2*n+1];
                if (node_set[l][2*n]) begin
                    cnt[l+1][n] = cnt[l][2*n];
                end else begin
                    cnt[l+1][n] = cnt[l][2*n+1] + 6'(1 << l);  // Left half all zero
                end
            end
        end
    end

    assign lzc   = cnt[6][0];
    assign valid = node_set[6][0];

endmodule

// File: src/fp_extract.sv
// Unpack, normalize and classify one operand word, zero latency
// Single values sit in the low 32 bits, the format comes with the word
// Output is the 65-bit internal operand plus the one-hot fclass vector
`timescale 1ns/1ps

module fp_extract (
    input  fp_unpack_pkg::fp_ext_in_t  ext_in,
    output fp_unpack_pkg::fp_ext_out_t ext_out
);

    import fp_unpack_pkg::*;

    logic               sign;
    logic [EXP_W-1:0]   exp_raw;    // Biased source exponent, zero extended
    logic [EXP_W-1:0]   rebias;
    logic [FRAC_W-1:0]  frac_al;    // Mantissa left aligned, zero filled
    logic               exp_ones;
    logic               exp_zero;
    logic               mant_zero;
    logic [63:0]        lzc_in;
    logic [5:0]         lzc;
    logic               lzc_valid;
    logic [6:0]         shamt;
    logic [EXP_W-1:0]   res_exp;
    logic [FRAC_W-1:0]  res_frac;
    logic [INT_W-1:0]   res_word;
    logic [CLASS_W-1:0] cls;

    fp_lzc64 lzc_i (
        .data_in (lzc_in),
        .lzc     (lzc),
        .valid   (lzc_valid)
    );

    always_comb begin
        if (ext_in.fmt == FMT_SINGLE) begin
            sign     = ext_in.data.sp.sign;
            exp_ones = &ext_in.data.sp.exp;
            exp_zero = ~|ext_in.data.sp.exp;
            exp_raw  = {4'd0, ext_in.data.sp.exp};
            frac_al  = {ext_in.data.sp.mant, 29'd0};
            rebias   = SP_REBIAS;
        end else begin
            sign     = ext_in.data.dp.sign;
            exp_ones = &ext_in.data.dp.exp;
            exp_zero = ~|ext_in.data.dp.exp;
            exp_raw  = {1'b0, ext_in.data.dp.exp};
            frac_al  = ext_in.data.dp.mant;
            rebias   = DP_REBIAS;
        end
        mant_zero = ~|frac_al;
    end

    assign lzc_in = {frac_al, 12'd0};
    assign shamt  = {1'b0, lzc} + 7'd1;  // Drops the leading one as well

    always_comb begin
        if (exp_ones) begin
            res_exp  = '1;
            res_frac = frac_al;  // Keeps the NaN payload
        end else if (!exp_zero) begin
            res_exp  = exp_raw + rebias;
            res_frac = frac_al;
        end else if (!mant_zero) begin
            res_exp  = rebias + 12'd1 - {5'd0, shamt};
            res_frac = frac_al << shamt;
        end else begin
            res_exp  = '0;
            res_frac = '0;
        end
    end

    always_comb begin
        cls = '0;
        if (exp_ones && !mant_zero) begin
            cls[frac_al[FRAC_W-1] ? CLS_QNAN : CLS_SNAN] = 1'b1;  // Sign ignored
        end else if (exp_ones) begin
            cls[sign ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
        end else if (exp_zero && mant_zero) begin
            cls[sign ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
        end else if (exp_zero) begin
            cls[sign ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
        end else begin
            cls[sign ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
        end
    end

    assign res_word       = {sign, res_exp, res_frac};
    assign ext_out.result = res_word;
    assign ext_out.cls    = cls;

    // Subnormal shift is only meaningful when the counter found a set bit
    always_comb begin
        if (!mant_zero) begin
            assert (lzc_valid)
                else $error("leading zero counter reports zero for a nonzero mantissa");
        end
    end

endmodule

// File: src/fp_unpack_cfg.sv
// Configuration and status registers of the unpack front end
// Holds the operand format and class mask, and a sticky record of
// the classes seen on results; clear or a config write empties it
`timescale 1ns/1ps

module fp_unpack_cfg (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              cfg_we,
    input  fp_unpack_pkg::fp_cfg_t            cfg_wdata,
    input  logic                              cfg_clear,
    input  logic                              res_valid,
    input  logic [fp_unpack_pkg::CLASS_W-1:0] res_cls,
    output fp_unpack_pkg::fp_cfg_t            cur_cfg,
    output logic [fp_unpack_pkg::CLASS_W-1:0] seen_classes
);

    import fp_unpack_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_cfg.fmt        <= FMT_SINGLE;
            cur_cfg.class_mask <= '0;
        end else if (cfg_we) begin
            cur_cfg <= cfg_wdata;  // Seen by operands from the next cycle
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seen_classes <= '0;
        end else if (cfg_clear || cfg_we) begin
            seen_classes <= '0;  // Wins over a result in the same cycle
        end else if (res_valid) begin
            seen_classes <= seen_classes | res_cls;
        end
    end

    // Results from the classifier carry exactly one class bit
    a_res_cls_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        res_valid |-> $onehot(res_cls)
    ) else $error("result class is not one-hot: %b", res_cls);

endmodule

// File: src/fp_class_pipe.sv
// Output register stage of the unpack front end
// Captures the classifier result on each operand strobe and forms
// the mask match, both one cycle after the strobe
`timescale 1ns/1ps

module fp_class_pipe (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    input  fp_unpack_pkg::fp_ext_out_t        ext_out,
    input  logic [fp_unpack_pkg::CLASS_W-1:0] class_mask,
    output logic                              out_valid,
    output fp_unpack_pkg::fp_ext_out_t        out,
    output logic                              out_match
);

    logic hit;

    assign hit = |(ext_out.cls & class_mask);  // Mask as it stands at capture

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_match <= 1'b0;
        end else begin
            out_valid <= in_valid;
            out_match <= in_valid & hit;
        end
    end

    // Payload holds between strobes
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out <= ext_out;
        end
    end

    a_match_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(out_match) |-> out_valid
    ) else $error("match strobe without a valid result");

endmodule

// File: src/fp_unpack_top.sv
// Top level of the FPU operand unpack and classify front end
// One operand per in_valid strobe, result one cycle later
// Configuration writes apply to operands from the next cycle
`timescale 1ns/1ps

module fp_unpack_top (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    input  fp_unpack_pkg::fp_word_u           in_data,
    input  logic                              cfg_we,
    input  fp_unpack_pkg::fp_cfg_t            cfg_wdata,
    input  logic                              cfg_clear,
    output fp_unpack_pkg::fp_cfg_t            cfg_rdata,
    output logic [fp_unpack_pkg::CLASS_W-1:0] seen_classes,
    output logic                              out_valid,
    output fp_unpack_pkg::fp_ext_out_t        out,
    output logic                              out_match
);

    import fp_unpack_pkg::*;

    fp_cfg_t     cur_cfg;
    fp_ext_in_t  ext_in;
    fp_ext_out_t ext_out;

    assign ext_in.data = in_data;
    assign ext_in.fmt  = cur_cfg.fmt;
    assign cfg_rdata   = cur_cfg;

    fp_unpack_cfg cfg_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .cfg_we       (cfg_we),
        .cfg_wdata    (cfg_wdata),
        .cfg_clear    (cfg_clear),
        .res_valid    (out_valid),
        .res_cls      (out.cls),
        .cur_cfg      (cur_cfg),
        .seen_classes (seen_classes)
    );

    fp_extract extract_i (
        .ext_in  (ext_in),
        .ext_out (ext_out)
    );

    fp_class_pipe pipe_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .ext_out    (ext_out),
        .class_mask (cur_cfg.class_mask),
        .out_valid  (out_valid),
        .out        (out),
        .out_match  (out_match)
    );

endmodule

// File: verification/fp_unpack_tb.sv
// Directed testbench for the FPU operand unpack and classify front end
// Drives fp_unpack_top through special values, subnormals, random streams,
// class mask matching, the sticky class record and reset defaults
`timescale 1ns/1ps

module fp_unpack_tb;

    import fp_unpack_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int N_RAND     = 200;
    // Rough cycle budget of all tests together
    localparam int TOTAL_CYC  = 10 + 8*3 + (23+52)*3 + 2*(N_RAND+6) + 60 + 60;

    logic               clk;
    logic               arst_n;
    logic               in_valid;
    fp_word_u           in_data;
    logic               cfg_we;
    fp_cfg_t            cfg_wdata;
    logic               cfg_clear;
    fp_cfg_t            cfg_rdata;
    logic [CLASS_W-1:0] seen_classes;
    logic               out_valid;
    fp_ext_out_t        dut_out;
    logic               out_match;

    fp_cfg_t mdl_cfg;  // Configuration the DUT should be using
    string   cur_test;
    int      test_errs;
    int      total_errs;
    int      tests_run;
    int      tests_failed;
    integer  seed;

    fp_unpack_top fp_unpack_top_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .cfg_we       (cfg_we),
        .cfg_wdata    (cfg_wdata),
        .cfg_clear    (cfg_clear),
        .cfg_rdata    (cfg_rdata),
        .seen_classes (seen_classes),
        .out_valid    (out_valid),
        .out          (dut_out),
        .out_match    (out_match)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(TOTAL_CYC * CLK_PERIOD * 2);
        $display("watchdog expired in test %s, the run did not finish in time", cur_test);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Reference model of the IEEE unpack and classify rules
    function automatic fp_ext_out_t ref_unpack(input fp_word_u w, input fmt_e fmt);
        fp_ext_out_t r;
        logic        s;
        logic [10:0] e;
        logic [51:0] f;
        logic        e_ones;
        logic        e_zero;
        logic [11:0] rb;
        int          lz;
        if (fmt == FMT_SINGLE) begin
            s      = w.sp.sign;
            e      = {3'd0, w.sp.exp};
            f      = {w.sp.mant, 29'd0};
            e_ones = (w.sp.exp == 8'hFF);
            e_zero = (w.sp.exp == 8'h00);
            rb     = 12'd1920;
        end else begin
            s      = w.dp.sign;
            e      = w.dp.exp;
            f      = w.dp.mant;
            e_ones = (w.dp.exp == 11'h7FF);
            e_zero = (w.dp.exp == 11'h000);
            rb     = 12'd1024;
        end
        r = '0;
        r.result.sign = s;
        if (e_ones) begin
            r.result.exp  = 12'hFFF;
            r.result.frac = f;
            if (f == '0) begin
                r.cls[s ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
            end else begin
                r.cls[f[51] ? CLS_QNAN : CLS_SNAN] = 1'b1;
            end
        end else if (!e_zero) begin
            r.result.exp  = {1'b0, e} + rb;
            r.result.frac = f;
            r.cls[s ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
        end else if (f != '0) begin
            lz = 0;
            while (!f[51-lz]) begin
                lz++;
            end
            r.result.exp  = rb + 12'd1 - 12'(lz + 1);  // Leading one drops out
            r.result.frac = f << (lz + 1);
            r.cls[s ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
        end else begin
            r.cls[s ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
        end
        return r;
    endfunction

    task automatic check_int(input string what, input fp_int_t exp_v, input fp_int_t act_v);
        if (exp_v !== act_v) begin
            $display("ERR %s %s: expected %h actual %h", cur_test, what, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic check_cls(input string what, input logic [CLASS_W-1:0] exp_v,
                             input logic [CLASS_W-1:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERR %s %s: expected %b actual %b", cur_test, what, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp_v, input logic act_v);
        if (exp_v !== act_v) begin
            $display("ERR %s %s: expected %b actual %b", cur_test, what, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic check_cfg(input string what, input fp_cfg_t exp_v, input fp_cfg_t act_v);
        if (exp_v !== act_v) begin
            $display("ERR %s %s: expected %h actual %h", cur_test, what, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("test %-16s %s (%0d errors)", cur_test,
                 (test_errs == 0) ? "passed" : "failed", test_errs);
    endtask

    // Runs on the falling edge one cycle after the strobe of w
    task automatic verify_result(input fp_word_u w);
        fp_ext_out_t e;
        e = ref_unpack(w, mdl_cfg.fmt);
        if (out_valid !== 1'b1) begin
            $display("%s: out_valid missing one cycle after operand %h", cur_test, w);
            test_errs++;
        end else begin
            check_int("result", e.result, dut_out.result);
            check_cls("class", e.cls, dut_out.cls);
            check_bit("match", |(e.cls & mdl_cfg.class_mask), out_match);
        end
    endtask

    task automatic apply_op(input fp_word_u w);
        @(posedge clk);
        in_valid <= 1'b1;
        in_data  <= w;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        verify_result(w);
    endtask

    task automatic write_cfg(input fmt_e fmt, input logic [CLASS_W-1:0] mask);
        fp_cfg_t c;
        c.fmt        = fmt;
        c.class_mask = mask;
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_wdata <= c;
        @(posedge clk);
        cfg_we  <= 1'b0;
        mdl_cfg = c;
        @(negedge clk);
        check_cfg("cfg_rdata", c, cfg_rdata);
    endtask

    task automatic reset_defaults();
        fp_cfg_t c;
        start_test("reset");
        c.fmt        = FMT_SINGLE;
        c.class_mask = '0;
        @(negedge clk);
        check_cfg("cfg_rdata", c, cfg_rdata);
        check_cls("seen_classes", '0, seen_classes);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("out_match", 1'b0, out_match);
        apply_op({32'hFFFF_FFFF, 32'h3FC0_0000});  // Read as single without a write
        end_test();
    endtask

    task automatic special_values_sp();
        start_test("special_sp");
        write_cfg(FMT_SINGLE, 10'b10_1001_0010);
        apply_op({32'hA5A5_5A5A, 32'h0000_0000});
        apply_op({32'hA5A5_5A5A, 32'h8000_0000});
        apply_op({32'h5A5A_A5A5, 32'h7F80_0000});
        apply_op({32'h5A5A_A5A5, 32'hFF80_0000});
        apply_op({32'h0000_0000, 32'h7FC0_0000});  // Quiet NaN
        apply_op({32'hFFFF_FFFF, 32'hFF80_0001});  // Signaling NaN with the sign set
        apply_op({32'h1234_5678, 32'h7F7F_FFFF});
        apply_op({32'h1234_5678, 32'h0080_0000});
        end_test();
    endtask

    task automatic subnormal_sweep();
        fp_word_u    w;
        logic [63:0] r;
        start_test("subnormal");
        write_cfg(FMT_SINGLE, 10'b00_0010_0100);
        for (int p = 0; p < 23; p++) begin
            r         = {$random(seed), $random(seed)};
            w         = r;
            w.sp.sign = (p % 2 == 1);
            w.sp.exp  = '0;
            w.sp.mant = (23'(1) << (22 - p)) | (r[22:0] & ((23'(1) << (22 - p)) - 23'd1));
            apply_op(w);
        end
        write_cfg(FMT_DOUBLE, 10'b00_0010_0000);
        for (int p = 0; p < 52; p++) begin
            r         = {$random(seed), $random(seed)};
            w.dp.sign = (p % 3 == 0);
            w.dp.exp  = '0;
            w.dp.mant = (52'(1) << (51 - p)) | (r[51:0] & ((52'(1) << (51 - p)) - 52'd1));
            apply_op(w);
        end
        end_test();
    endtask

    task automatic stream_random(input fmt_e fmt);
        fp_word_u ops [N_RAND];
        for (int i = 0; i < N_RAND; i++) begin
            ops[i] = {$random(seed), $random(seed)};
            if (i % 7 == 3) begin
                if (fmt == FMT_SINGLE) begin
                    ops[i].sp.exp = '0;
                end else begin
                    ops[i].dp.exp = '0;
                end
            end else if (i % 11 == 5) begin
                if (fmt == FMT_SINGLE) begin
                    ops[i].sp.exp = '1;
                end else begin
                    ops[i].dp.exp = '1;
                end
            end
        end
        for (int i = 0; i < N_RAND; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= ops[i];
            @(negedge clk);
            if (i > 0) begin
                verify_result(ops[i-1]);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        verify_result(ops[N_RAND-1]);
    endtask

    task automatic random_streams();
        start_test("random_stream");
        write_cfg(FMT_DOUBLE, 10'b11_0100_0101);
        stream_random(FMT_DOUBLE);
        write_cfg(FMT_SINGLE, 10'b00_1011_1000);
        stream_random(FMT_SINGLE);
        end_test();
    endtask

    task automatic class_mask_match();
        fp_cfg_t  nxt;
        fp_word_u w;
        start_test("class_mask");
        for (int k = 0; k < 2; k++) begin
            write_cfg(FMT_DOUBLE, (k == 0) ? 10'b10_0100_1000 : 10'b01_1010_0011);
            apply_op(64'h3FF0_0000_0000_0000);
            apply_op(64'hBFF0_0000_0000_0000);
            apply_op(64'h7FF8_0000_0000_0000);
            apply_op(64'h7FF0_0000_0000_0001);
            apply_op(64'h8000_0000_0000_0000);
            apply_op(64'h0000_0000_0000_0000);
            apply_op(64'h7FF0_0000_0000_0000);
            apply_op(64'h8000_0000_0000_0001);
        end
        // A write on the same cycle as an operand takes effect for the next one
        write_cfg(FMT_SINGLE, '0);
        nxt.fmt        = FMT_DOUBLE;
        nxt.class_mask = 10'b00_0100_0000;
        w              = 64'h3FF0_0000_3F80_0000;
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_wdata <= nxt;
        in_valid  <= 1'b1;
        in_data   <= w;
        @(posedge clk);
        cfg_we <= 1'b0;
        @(negedge clk);
        verify_result(w);
        mdl_cfg = nxt;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        verify_result(w);
        end_test();
    endtask

    task automatic sticky_record();
        fp_word_u           ops [5];
        fp_ext_out_t        e;
        logic [CLASS_W-1:0] seen_exp;
        start_test("sticky_record");
        write_cfg(FMT_SINGLE, 10'b00_0000_0001);
        check_cls("seen after write", '0, seen_classes);
        ops[0]   = 64'h0000_0000_0000_0000;
        ops[1]   = 64'h0000_0000_FF80_0000;
        ops[2]   = 64'h0000_0000_7F80_0003;
        ops[3]   = 64'h0000_0000_8000_0100;
        ops[4]   = 64'h0000_0000_4049_0FDB;
        seen_exp = '0;
        for (int i = 0; i < 5; i++) begin
            apply_op(ops[i]);
            e        = ref_unpack(ops[i], mdl_cfg.fmt);
            seen_exp = seen_exp | e.cls;
        end
        @(posedge clk);
        @(negedge clk);
        check_cls("seen_classes", seen_exp, seen_classes);
        check_cfg("cfg_rdata", mdl_cfg, cfg_rdata);
        @(posedge clk);
        cfg_clear <= 1'b1;
        @(posedge clk);
        cfg_clear <= 1'b0;
        @(negedge clk);
        check_cls("seen after clear", '0, seen_classes);
        // Clear lands on the same edge as a result update
        @(posedge clk);
        in_valid <= 1'b1;
        in_data  <= ops[4];
        @(posedge clk);
        in_valid  <= 1'b0;
        cfg_clear <= 1'b1;
        @(negedge clk);
        check_bit("out_valid", 1'b1, out_valid);
        @(posedge clk);
        cfg_clear <= 1'b0;
        @(negedge clk);
        check_cls("seen after clear with result", '0, seen_classes);
        end_test();
    endtask

    initial begin
        seed         = 32'h3872;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "init";
        mdl_cfg.fmt        = FMT_SINGLE;
        mdl_cfg.class_mask = '0;
        arst_n    = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        cfg_we    = 1'b0;
        cfg_wdata = '0;
        cfg_clear = 1'b0;
        #1 arst_n = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        reset_defaults();
        special_values_sp();
        subnormal_sweep();
        random_streams();
        class_mask_match();
        sticky_record();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
src/fp_unpack_pkg.sv
src/fp_lzc64.sv
src/fp_extract.sv
src/fp_unpack_cfg.sv
src/fp_class_pipe.sv
src/fp_unpack_top.sv
verification/fp_unpack_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compiles the unpack front end and its testbench with Verilator and runs it
# Exit status is 0 only when the testbench reports a full pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f sources.f \
    --top-module fp_unpack_tb \
    -o fp_unpack_sim \
    && ./obj_dir/fp_unpack_sim | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

exit 0
